// ==== filelist.f ====
verilog/uart_line_pkg.sv
verilog/cmd_pkg.sv
verilog/uart_tx.sv
verilog/uart_rx.sv
verilog/cmd_sequencer.sv
verilog/uart_cmd_bridge.sv
dv/tb_clkgen.sv
dv/tb_uart_cmd_bridge.sv

// ==== run.sh ====
#!/bin/sh
# Build the UART command bridge testbench with Verilator and run it.
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -j 0 -f filelist.f \
    --top-module tb_uart_cmd_bridge -o sim_tb; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
printf '%s\n' "$out"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qF '*** PASSED ***'; then
  exit 0
fi
exit 1

// ==== dv/tb_uart_cmd_bridge.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_uart_cmd_bridge
  import cmd_pkg::*;
();

  localparam int bit_clks   = 16;
  localparam int gap_clks   = 20;
  localparam int tmo_clks   = 400;
  localparam int frame_clks = 11 * bit_clks;

  typedef struct packed {
    logic [10:0] frame;
    logic        chk_gap;  // Second frame of a write.
  } exp_frame_t;

  logic       clk;
  logic       rst_n;
  cmd_t       cmd;
  logic       cmd_vld;
  logic       cmd_rdy;
  logic       rx;
  logic       tx;
  read_rsp_t  read_rsp;
  logic       read_vld;
  int         cyc = 0;
  int         frames_seen = 0;

  logic [10:0] frame_q[$];
  int          frame_start_q[$];
  exp_frame_t  exp_frame_q[$];
  read_rsp_t   exp_rsp_q[$];

  tb_clkgen #(.period_ns(8), .reset_cycles(3)) u_clkgen (.clk(clk), .rst_n(rst_n));

  uart_cmd_bridge #(
    .clks_per_bit       (bit_clks),
    .gap_cycles         (gap_clks),
    .rsp_timeout_cycles (tmo_clks)
  ) u_dut (
    .clk      (clk),
    .rst_n    (rst_n),
    .cmd      (cmd),
    .cmd_vld  (cmd_vld),
    .cmd_rdy  (cmd_rdy),
    .rx       (rx),
    .tx       (tx),
    .read_rsp (read_rsp),
    .read_vld (read_vld)
  );

  always @(posedge clk)
    cyc <= cyc + 1;

  // Start, data LSB first, odd parity, stop; bit 0 goes out first.
  function automatic logic [10:0] expect_frame(input logic [7:0] b);
    logic par;
    par = ($countones(b) % 2 == 0);
    return {1'b1, par, b, 1'b0};
  endfunction

  function automatic read_rsp_t expect_rsp(input logic [7:0] b, input logic flip_par,
                                           input logic low_stop, input logic answered);
    read_rsp_t r;
    r.data = b;
    if (!answered)
    begin
      r.status = rsp_timeout;
      r.data   = 8'h00;
    end
    else if (low_stop)
      r.status = rsp_frame_err;
    else if (flip_par)
      r.status = rsp_parity_err;
    else
      r.status = rsp_ok;
    return r;
  endfunction

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("*** FAILED ***");
    $fatal(1, "Simulation stopped on the first failure.");
  endtask

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (expected !== actual)
      report_failure($sformatf("[ERROR] %s: expected 0x%0h, actual 0x%0h",
                               name, expected, actual));
  endtask

  task automatic wait_step(inout int n, input int limit, input string what);
    n++;
    if (n > limit)
      report_failure($sformatf("Timeout: %s never came", what));
    else
      @(negedge clk);
  endtask

  task automatic send_cmd(input cmd_t c);
    int n;
    n = 0;
    @(posedge clk);
    cmd     <= c;
    cmd_vld <= 1'b1;
    @(negedge clk);
    while (!cmd_rdy)
      wait_step(n, 2000, "cmd_rdy before a command");
    @(posedge clk);  // Accepted on this edge.
    cmd_vld <= 1'b0;
    @(negedge clk);
    check("cmd_rdy after accept", 32'(1'b0), 32'(cmd_rdy));
  endtask

  task automatic poke_busy(input cmd_t c);
    repeat (40) @(posedge clk);
    cmd     <= c;
    cmd_vld <= 1'b1;
    @(negedge clk);
    check("cmd_rdy while busy", 32'(1'b0), 32'(cmd_rdy));
    @(posedge clk);
    cmd_vld <= 1'b0;
  endtask

  task automatic wait_done(input string what);
    int n;
    n = 0;
    @(negedge clk);
    while (!cmd_rdy)
      wait_step(n, 2000, what);
    repeat (2) @(negedge clk);
    check("frames left after command", 32'(0), 32'(exp_frame_q.size()));
    check("reads left after command", 32'(0), 32'(exp_rsp_q.size()));
  endtask

  task automatic drive_rx_frame(input logic [7:0] b, input logic flip_par,
                                input logic low_stop);
    logic [10:0] f;
    int          k;
    f     = expect_frame(b);
    f[9]  = f[9] ^ flip_par;
    f[10] = ~low_stop;
    for (k = 0; k < 11; k++)
    begin
      @(posedge clk);
      rx <= f[0];
      f = f >> 1;
      repeat (bit_clks - 1) @(posedge clk);
    end
    @(posedge clk);
    rx <= 1'b1;
  endtask

  task automatic run_write(input cmd_t c, input logic poke);
    exp_frame_q.push_back(exp_frame_t'{frame: expect_frame({c.op, c.addr}), chk_gap: 1'b0});
    exp_frame_q.push_back(exp_frame_t'{frame: expect_frame(c.data), chk_gap: 1'b1});
    send_cmd(c);
    if (poke)
      poke_busy(c);
    wait_done("write completion");
  endtask

  task automatic run_read(input cmd_t c, input logic [7:0] b, input logic flip_par,
                          input logic low_stop, input logic answered);
    int n;
    int seen;
    n = 0;
    exp_frame_q.push_back(exp_frame_t'{frame: expect_frame({c.op, c.addr}), chk_gap: 1'b0});
    exp_rsp_q.push_back(expect_rsp(b, flip_par, low_stop, answered));
    seen = frames_seen;
    send_cmd(c);
    while (frames_seen == seen)
      wait_step(n, 1000, "read request frame");
    if (answered)
    begin
      repeat ($urandom_range(2, 12)) @(posedge clk);
      drive_rx_frame(b, flip_par, low_stop);
    end
    wait_done("read response");
  endtask

  // Samples tx every cycle of a frame; each bit must hold for bit_clks cycles.
  initial
  begin : line_monitor
    logic [10:0] bits;
    logic        cur;
    logic        prev;
    int          start;
    int          k;
    prev = 1'b1;
    forever
    begin
      @(negedge clk);
      if (rst_n && prev && !tx)
      begin
        start = cyc;
        for (k = 0; k < frame_clks; k++)
        begin
          if (k > 0)
            @(negedge clk);
          if (k % bit_clks == 0)
            cur = tx;
          else
            check("tx bit width", 32'(cur), 32'(tx));
          if (k % bit_clks == bit_clks - 1)
            bits = {cur, bits[10:1]};
        end
        frame_q.push_back(bits);
        frame_start_q.push_back(start);
        frames_seen++;
      end
      prev = tx;
    end
  end

  initial
  begin : compare_proc
    exp_frame_t  ef;
    read_rsp_t   er;
    logic [10:0] got;
    int          start;
    int          prev_end;
    prev_end = 0;
    forever
    begin
      @(negedge clk);
      if (frame_q.size() > 0)
      begin
        got   = frame_q.pop_front();
        start = frame_start_q.pop_front();
        if (exp_frame_q.size() == 0)
          report_failure("A frame appeared on tx with no command pending.");
        else
        begin
          ef = exp_frame_q.pop_front();
          check("tx frame", 32'(ef.frame), 32'(got));
          if (ef.chk_gap)
            check("write gap", 32'(gap_clks), 32'(start - prev_end));
          prev_end = start + frame_clks;
        end
      end
      if (read_vld)
      begin
        if (exp_rsp_q.size() == 0)
          report_failure("read_vld pulsed with no read pending.");
        else
        begin
          er = exp_rsp_q.pop_front();
          check("read response", 32'(er), 32'(read_rsp));
          if (er.status == rsp_timeout)
            check("timeout delay", 32'(1'b1), 32'((cyc - prev_end) >= tmo_clks));
        end
      end
    end
  end

  initial
  begin : stimulus
    cmd_t c;
    int   i;
    int   n;
    cmd     = '0;
    cmd_vld = 1'b0;
    rx      = 1'b1;
    c       = '0;
    n       = 0;
    void'($urandom(74318));
    @(negedge clk);
    while (!rst_n)
      wait_step(n, 20, "reset release");
    @(negedge clk);
    check("cmd_rdy after reset", 32'(1'b1), 32'(cmd_rdy));
    check("tx after reset", 32'(1'b1), 32'(tx));
    check("read_vld after reset", 32'(1'b0), 32'(read_vld));
    for (i = 0; i < 20; i++)
    begin
      c.op   = op_write;
      c.addr = 7'($urandom);
      c.data = 8'($urandom);
      run_write(c, 1'b0);
    end
    for (i = 0; i < 8; i++)
    begin
      c.op   = op_read;
      c.addr = 7'($urandom);
      run_read(c, 8'($urandom), 1'b0, 1'b0, 1'b1);
    end
    c.addr = 7'($urandom);
    run_read(c, 8'($urandom), 1'b1, 1'b0, 1'b1);  // Flipped parity.
    run_read(c, 8'($urandom), 1'b0, 1'b1, 1'b1);  // Low stop bit.
    run_read(c, 8'h00, 1'b0, 1'b0, 1'b0);  // Nobody answers.
    c.op   = op_write;
    c.data = 8'($urandom);
    run_write(c, 1'b1);  // Extra cmd_vld while busy.
    drive_rx_frame(8'($urandom), 1'b0, 1'b0);  // Stray frame while idle.
    repeat (40) @(negedge clk);
    check("frames left at end", 32'(0), 32'(frame_q.size()));
    check("reads left at end", 32'(0), 32'(exp_rsp_q.size()));
    $display("*** PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

// ==== dv/tb_clkgen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
  parameter int period_ns    = 8,
  parameter int reset_cycles = 3
) (
  output logic clk,
  output logic rst_n
);

  initial
  begin
    clk = 1'b0;
    forever #(period_ns / 2) clk = ~clk;
  end

  initial
  begin
    rst_n = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    rst_n <= 1'b1;  // Released on a rising edge.
  end

endmodule

`default_nettype wire

// ==== verilog/uart_cmd_bridge.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_cmd_bridge
  import uart_line_pkg::*;
  import cmd_pkg::*;
#(
  parameter int clks_per_bit       = 434,
  parameter int gap_cycles         = 100,
  parameter int rsp_timeout_cycles = 10000
) (
  input  wire        clk,
  input  wire        rst_n,
  input  wire cmd_t  cmd,
  input  wire        cmd_vld,
  output logic       cmd_rdy,
  input  wire        rx,
  output logic       tx,
  output read_rsp_t  read_rsp,
  output logic       read_vld
);

  logic [7:0] tx_byte;
  logic       tx_start;
  logic       tx_busy;
  rx_frame_t  rx_frame;
  logic       rx_vld;

  cmd_sequencer #(
    .gap_cycles         (gap_cycles),
    .rsp_timeout_cycles (rsp_timeout_cycles)
  ) u_seq (
    .clk      (clk),
    .rst_n    (rst_n),
    .cmd      (cmd),
    .cmd_vld  (cmd_vld),
    .cmd_rdy  (cmd_rdy),
    .tx_byte  (tx_byte),
    .tx_start (tx_start),
    .tx_busy  (tx_busy),
    .rx_frame (rx_frame),
    .rx_vld   (rx_vld),
    .read_rsp (read_rsp),
    .read_vld (read_vld)
  );

  uart_tx #(
    .clks_per_bit (clks_per_bit)
  ) u_tx (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_byte  (tx_byte),
    .tx_start (tx_start),
    .tx       (tx),
    .tx_busy  (tx_busy)
  );

  uart_rx #(
    .clks_per_bit (clks_per_bit)
  ) u_rx (
    .clk      (clk),
    .rst_n    (rst_n),
    .rx       (rx),
    .rx_frame (rx_frame),
    .rx_vld   (rx_vld)
  );

endmodule

`default_nettype wire

// ==== verilog/cmd_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module cmd_sequencer
  import uart_line_pkg::*;
  import cmd_pkg::*;
#(
  parameter int gap_cycles         = 100,
  parameter int rsp_timeout_cycles = 10000
) (
  input  wire        clk,
  input  wire        rst_n,
  input  wire cmd_t  cmd,
  input  wire        cmd_vld,
  output logic       cmd_rdy,
  output logic [7:0] tx_byte,
  output logic       tx_start,
  input  wire        tx_busy,
  input  wire rx_frame_t rx_frame,
  input  wire        rx_vld,
  output read_rsp_t  read_rsp,
  output logic       read_vld
);

  // Frame end detection and the tx_start register take three gap cycles.
  localparam int gap_w = $clog2(gap_cycles);
  localparam logic [gap_w-1:0] gap_last = gap_w'(gap_cycles - 3);
  localparam int tmo_w = $clog2(rsp_timeout_cycles);
  localparam logic [tmo_w-1:0] tmo_last = tmo_w'(rsp_timeout_cycles - 1);

  seq_state_e       state;
  cmd_t             cmd_q;
  logic [gap_w-1:0] gap_cnt;
  logic [tmo_w-1:0] tmo_cnt;
  logic             accept;
  logic             frame_done;
  logic             gap_done;
  logic             tmo_done;
  rsp_status_e      rx_status;

  assign cmd_rdy    = (state == seq_idle) && !read_vld;
  assign accept     = cmd_vld && cmd_rdy;
  assign frame_done = !tx_busy && !tx_start;  // Busy has not risen while tx_start is high.
  assign gap_done   = (state == seq_gap) && (gap_cnt == gap_last);
  assign tmo_done   = (tmo_cnt == tmo_last);

  always_comb
  begin
    if (rx_frame.stop_err)
      rx_status = rsp_frame_err;
    else if (rx_frame.parity_err)
      rx_status = rsp_parity_err;
    else
      rx_status = rsp_ok;
  end

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      cmd_q   <= cmd;
      tx_byte <= {cmd.op, cmd.addr};
    end
    else if (gap_done)
      tx_byte <= cmd_q.data;
    if (state == seq_wait_rsp)
    begin
      if (rx_vld)
        read_rsp <= '{status: rx_status, data: rx_frame.data};
      else
        read_rsp <= '{status: rsp_timeout, data: 8'h00};
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= seq_idle;
      gap_cnt  <= '0;
      tmo_cnt  <= '0;
      tx_start <= 1'b0;
      read_vld <= 1'b0;
    end
    else
    begin
      tx_start <= 1'b0;
      read_vld <= 1'b0;
      case (state)
        seq_idle:
        begin
          if (accept)
          begin
            state    <= seq_send_hi;
            tx_start <= 1'b1;
          end
        end
        seq_send_hi:
        begin
          gap_cnt <= '0;
          tmo_cnt <= '0;
          if (frame_done)
            state <= (cmd_q.op == op_write) ? seq_gap : seq_wait_rsp;
        end
        seq_gap:
        begin
          gap_cnt <= gap_cnt + 1'b1;
          if (gap_done)
          begin
            state    <= seq_send_lo;
            tx_start <= 1'b1;
          end
        end
        seq_send_lo:
        begin
          if (frame_done)
            state <= seq_idle;
        end
        default:
        begin
          tmo_cnt <= tmo_cnt + 1'b1;
          if (rx_vld || tmo_done)  // Timeout runs until a whole frame is received.
          begin
            state    <= seq_idle;
            read_vld <= 1'b1;
          end
        end
      endcase
    end
  end

  a_read_from_wait: assert property (@(posedge clk) disable iff (!rst_n)
    read_vld |-> $past(state) == seq_wait_rsp)
    else $error("cmd_sequencer: read_vld outside response wait");

endmodule

`default_nettype wire

// ==== verilog/uart_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_rx
  import uart_line_pkg::*;
#(
  parameter int clks_per_bit = 434
) (
  input  wire        clk,
  input  wire        rst_n,
  input  wire        rx,
  output rx_frame_t  rx_frame,
  output logic       rx_vld
);

  localparam int cnt_w = $clog2(clks_per_bit);
  localparam logic [cnt_w-1:0] cnt_last = cnt_w'(clks_per_bit - 1);
  localparam logic [cnt_w-1:0] half_last = cnt_w'(clks_per_bit / 2 - 1);
  localparam int idx_w = $clog2(data_bits);
  localparam logic [idx_w-1:0] idx_last = idx_w'(data_bits - 1);

  rx_state_e            state;
  logic                 rx_s1;
  logic                 rx_s2;
  logic                 rx_d;
  logic                 rx_fall;
  logic [cnt_w-1:0]     bit_cnt;
  logic [idx_w-1:0]     bit_idx;
  logic [data_bits-1:0] data_q;
  logic                 parity_q;

  assign rx_fall = rx_d & ~rx_s2;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_s1 <= 1'b1;  // Line idles high.
      rx_s2 <= 1'b1;
      rx_d  <= 1'b1;
    end
    else
    begin
      rx_s1 <= rx;
      rx_s2 <= rx_s1;
      rx_d  <= rx_s2;
    end
  end

  always_ff @(posedge clk)
  begin
    if ((state == rx_st_data) && (bit_cnt == cnt_last))
      data_q[bit_idx] <= rx_s2;
    if ((state == rx_st_parity) && (bit_cnt == cnt_last))
      parity_q <= rx_s2;
    if ((state == rx_st_stop) && (bit_cnt == cnt_last))
    begin
      rx_frame.data       <= data_q;
      rx_frame.parity_err <= ~^{data_q, parity_q};
      rx_frame.stop_err   <= ~rx_s2;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state   <= rx_st_idle;
      bit_cnt <= '0;
      bit_idx <= '0;
      rx_vld  <= 1'b0;
    end
    else
    begin
      rx_vld <= 1'b0;
      case (state)
        rx_st_idle:
        begin
          bit_cnt <= '0;
          if (rx_fall)
            state <= rx_st_start;
        end
        rx_st_start:
        begin
          if (bit_cnt == half_last)
          begin
            bit_cnt <= '0;
            bit_idx <= '0;
            state   <= rx_s2 ? rx_st_idle : rx_st_data;  // Glitch goes back to idle.
          end
          else
            bit_cnt <= bit_cnt + 1'b1;
        end
        default:
        begin
          if (bit_cnt == cnt_last)
          begin
            bit_cnt <= '0;
            if (state == rx_st_data)
            begin
              bit_idx <= bit_idx + 1'b1;
              if (bit_idx == idx_last)
                state <= rx_st_parity;
            end
            else if (state == rx_st_parity)
              state <= rx_st_stop;
            else
            begin
              state  <= rx_st_idle;
              rx_vld <= 1'b1;
            end
          end
          else
            bit_cnt <= bit_cnt + 1'b1;
        end
      endcase
    end
  end

  a_vld_single: assert property (@(posedge clk) disable iff (!rst_n)
    rx_vld |=> !rx_vld)
    else $error("uart_rx: rx_vld held for two cycles");

endmodule

`default_nettype wire

// ==== verilog/uart_tx.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_tx
  import uart_line_pkg::*;
#(
  parameter int clks_per_bit = 434
) (
  input  wire        clk,
  input  wire        rst_n,
  input  wire  [7:0] tx_byte,
  input  wire        tx_start,
  output logic       tx,
  output logic       tx_busy
);

  localparam int cnt_w = $clog2(clks_per_bit);
  localparam logic [cnt_w-1:0] cnt_last = cnt_w'(clks_per_bit - 1);
  localparam int idx_w = $clog2(data_bits);
  localparam logic [idx_w-1:0] idx_last = idx_w'(data_bits - 1);

  tx_state_e            state;
  logic [cnt_w-1:0]     bit_cnt;
  logic [idx_w-1:0]     bit_idx;
  logic [data_bits-1:0] byte_q;
  logic                 parity;
  logic                 bit_done;

  assign bit_done = (bit_cnt == cnt_last);

  always_ff @(posedge clk)
  begin
    if (tx_start && (state == tx_st_idle))
    begin
      byte_q <= tx_byte;
      parity <= ~^tx_byte;  // Odd parity over data and parity bit.
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state   <= tx_st_idle;
      bit_cnt <= '0;
      bit_idx <= '0;
      tx      <= 1'b1;
      tx_busy <= 1'b0;
    end
    else if (state == tx_st_idle)
    begin
      if (tx_start)
      begin
        state   <= tx_st_start;
        bit_cnt <= '0;
        tx      <= 1'b0;  // Start bit.
        tx_busy <= 1'b1;
      end
    end
    else if (bit_done)
    begin
      bit_cnt <= '0;
      case (state)
        tx_st_start:
        begin
          state   <= tx_st_data;
          bit_idx <= '0;
          tx      <= byte_q[0];
        end
        tx_st_data:
        begin
          if (bit_idx == idx_last)
          begin
            state <= tx_st_parity;
            tx    <= parity;
          end
          else
          begin
            bit_idx <= bit_idx + 1'b1;
            tx      <= byte_q[bit_idx + 1'b1];  // LSB first.
          end
        end
        tx_st_parity:
        begin
          state <= tx_st_stop;
          tx    <= 1'b1;
        end
        default:
        begin
          state   <= tx_st_idle;
          tx_busy <= 1'b0;  // Stop bit complete.
        end
      endcase
    end
    else
    begin
      bit_cnt <= bit_cnt + 1'b1;
    end
  end

  a_start_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
    tx_start |-> !tx_busy)
    else $error("uart_tx: tx_start while a frame is in flight");

endmodule

`default_nettype wire

// ==== verilog/cmd_pkg.sv ====
`default_nettype none

package cmd_pkg;

  typedef enum logic {
    op_read  = 1'b0,
    op_write = 1'b1
  } opcode_e;

  typedef struct packed {
    opcode_e    op;
    logic [6:0] addr;
    logic [7:0] data;
  } cmd_t;

  typedef enum logic [1:0] {
    rsp_ok,
    rsp_parity_err,
    rsp_frame_err,
    rsp_timeout
  } rsp_status_e;

  typedef struct packed {
    rsp_status_e status;
    logic [7:0]  data;
  } read_rsp_t;

  typedef enum logic [2:0] {
    seq_idle,
    seq_send_hi,
    seq_gap,
    seq_send_lo,
    seq_wait_rsp
  } seq_state_e;

endpackage

`default_nettype wire

// ==== verilog/uart_line_pkg.sv ====
`default_nettype none

package uart_line_pkg;

  localparam int data_bits  = 8;
  localparam int frame_bits = 11;  // Start, data, parity and stop.

  typedef struct packed {
    logic [data_bits-1:0] data;
    logic                 parity_err;  // Even ones count over data and parity.
    logic                 stop_err;    // Stop bit sampled low.
  } rx_frame_t;

  typedef enum logic [2:0] {
    tx_st_idle,
    tx_st_start,
    tx_st_data,
    tx_st_parity,
    tx_st_stop
  } tx_state_e;

  typedef enum logic [2:0] {
    rx_st_idle,
    rx_st_start,
    rx_st_data,
    rx_st_parity,
    rx_st_stop
  } rx_state_e;

endpackage

`default_nettype wire
